//--- src/maint_pkg.sv
/*
 * shared types and constants for the memory maintenance front end
 * widths, byte-lane control, address window and init phase encoding
 */
`default_nettype none

package maint_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] data_t;   // memory data word
    typedef logic [3:0]  ctrl_t;   // byte-lane enables

    // all lanes on, full word access
    localparam ctrl_t CTRL_FULL = 4'b1111;

    localparam int unsigned WORD_BYTES = 4;

    // controller sees a 64 MiB window, low 26 bits
    localparam addr_t ADDR_WINDOW_MASK = 32'h03ff_ffff;

    // init phases in the order they run
    typedef enum logic [2:0] {
        ST_CALIB,    // waiting on controller calibration
        ST_ZERO,     // zero fill of the low region
        ST_LOAD,     // boot image written from loader stream
        ST_VERIFY,   // image read back and summed
        ST_RUN       // user bus owns memory
    } init_state_e;

endpackage

`default_nettype wire

//--- src/init_sequencer.sv
/*
 * init phase FSM
 * calibration wait, zero fill, image load, readback, then run
 */
`default_nettype none

module init_sequencer (
    input  wire                    clk,
    input  wire                    i_rst_n,
    input  wire                    i_calib_done,
    input  wire                    i_zero_done,
    input  wire                    i_load_done,
    input  wire                    i_verify_done,
    output logic                   o_zero_active,
    output logic                   o_load_active,
    output logic                   o_verify_active,
    output maint_pkg::init_state_e o_state
);
    import maint_pkg::*;

    init_state_e state_q;
    init_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_CALIB:  if (i_calib_done)  state_d = ST_ZERO;
            ST_ZERO:   if (i_zero_done)   state_d = ST_LOAD;
            ST_LOAD:   if (i_load_done)   state_d = ST_VERIFY;
            ST_VERIFY: if (i_verify_done) state_d = ST_RUN;
            default:   state_d = state_q;  // run holds until reset
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_CALIB;
        end else begin
            state_q <= state_d;
        end
    end

    // one engine active per phase
    assign o_zero_active   = (state_q == ST_ZERO);
    assign o_load_active   = (state_q == ST_LOAD);
    assign o_verify_active = (state_q == ST_VERIFY);
    assign o_state         = state_q;

    // phases never skip or go back
    a_state_step: assert property (@(posedge clk) disable iff (!i_rst_n)
        (state_q != $past(state_q)) |-> (int'(state_q) == int'($past(state_q)) + 1))
        else $error("init_sequencer: state left %0d for %0d", $past(state_q), state_q);

endmodule

`default_nettype wire

//--- src/zero_filler.sv
/*
 * zero fill engine
 * one full-word write per word address below ZERO_BYTES
 */
`default_nettype none

module zero_filler #(
    parameter int unsigned ZERO_BYTES = 64
) (
    input  wire              clk,
    input  wire              i_rst_n,
    input  wire              i_active,
    input  wire              i_mem_busy,
    output logic             o_wr_en,
    output maint_pkg::addr_t o_addr,
    output logic             o_done
);
    import maint_pkg::*;

    logic  wr_en_q;
    addr_t addr_q;
    logic  done_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_en_q <= 1'b0;
            addr_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            if (wr_en_q && i_mem_busy) begin
                wr_en_q <= 1'b0;                            // controller took it
                addr_q  <= addr_q + addr_t'(WORD_BYTES);
            end else if (i_active && !wr_en_q && !i_mem_busy && addr_q < ZERO_BYTES) begin
                wr_en_q <= 1'b1;
            end
            // last write must finish before the phase ends
            if (i_active && addr_q >= ZERO_BYTES && !wr_en_q && !i_mem_busy)
                done_q <= 1'b1;
        end
    end

    assign o_wr_en = wr_en_q;
    assign o_addr  = addr_q;
    assign o_done  = done_q;

endmodule

`default_nettype wire

//--- src/image_loader.sv
/*
 * boot image loader
 * takes loader word strobes, writes them from address 0 up
 * and keeps the load checksum
 */
`default_nettype none

module image_loader #(
    parameter int unsigned IMAGE_BYTES = 32
) (
    input  wire              clk,
    input  wire              i_rst_n,
    input  wire              i_active,
    input  wire              i_ld_we,
    input  maint_pkg::data_t i_ld_data,
    input  wire              i_mem_busy,
    output logic             o_wr_en,
    output maint_pkg::addr_t o_addr,
    output maint_pkg::data_t o_wdata,
    output maint_pkg::data_t o_checksum,
    output logic             o_done
);
    import maint_pkg::*;

    typedef enum logic [1:0] {
        LD_IDLE,   // waiting for a strobe
        LD_REQ,    // write held until busy
        LD_WAIT    // controller working
    } ld_state_e;

    ld_state_e state_q;
    addr_t     addr_q;
    data_t     data_q;
    data_t     sum_q;
    logic      done_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= LD_IDLE;
            addr_q  <= '0;
            sum_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            case (state_q)
                LD_IDLE: begin
                    // strobes outside these conditions are dropped
                    if (i_active && i_ld_we && !i_mem_busy && !done_q) begin
                        state_q <= LD_REQ;
                        sum_q   <= sum_q + i_ld_data;   // wraps mod 2^32
                    end
                end
                LD_REQ: begin
                    if (i_mem_busy) begin
                        state_q <= LD_WAIT;
                        addr_q  <= addr_q + addr_t'(WORD_BYTES);
                    end
                end
                default: begin
                    if (!i_mem_busy) begin
                        state_q <= LD_IDLE;
                        if (addr_q >= IMAGE_BYTES)
                            done_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    // word held for the whole request
    always_ff @(posedge clk) begin
        if (state_q == LD_IDLE && i_ld_we)
            data_q <= i_ld_data;
    end

    assign o_wr_en    = (state_q == LD_REQ);
    assign o_addr     = addr_q;
    assign o_wdata    = data_q;
    assign o_checksum = sum_q;
    assign o_done     = done_q;

endmodule

`default_nettype wire

//--- src/readback_checker.sv
/*
 * image readback engine
 * reads every image word, sums them and compares with the load checksum
 */
`default_nettype none

module readback_checker #(
    parameter int unsigned IMAGE_BYTES = 32
) (
    input  wire              clk,
    input  wire              i_rst_n,
    input  wire              i_active,
    input  wire              i_mem_busy,
    input  maint_pkg::data_t i_mem_rdata,
    input  maint_pkg::data_t i_load_checksum,
    output logic             o_rd_en,
    output maint_pkg::addr_t o_addr,
    output logic             o_done,
    output logic             o_checksum_match
);
    import maint_pkg::*;

    typedef enum logic [1:0] {
        RB_ISSUE,   // next word or finish
        RB_REQ,     // read held until busy
        RB_WAIT     // data arrives on busy fall
    } rb_state_e;

    rb_state_e state_q;
    addr_t     addr_q;
    data_t     sum_q;
    logic      done_q;
    logic      match_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= RB_ISSUE;
            addr_q  <= '0;
            sum_q   <= '0;
            done_q  <= 1'b0;
            match_q <= 1'b0;
        end else begin
            case (state_q)
                RB_ISSUE: begin
                    if (i_active && !done_q && !i_mem_busy) begin
                        if (addr_q < IMAGE_BYTES) begin
                            state_q <= RB_REQ;
                        end else begin
                            done_q  <= 1'b1;
                            match_q <= (sum_q == i_load_checksum);  // held until reset
                        end
                    end
                end
                RB_REQ: begin
                    if (i_mem_busy) begin
                        state_q <= RB_WAIT;
                        addr_q  <= addr_q + addr_t'(WORD_BYTES);
                    end
                end
                default: begin
                    // first non-busy cycle carries the read data
                    if (!i_mem_busy) begin
                        state_q <= RB_ISSUE;
                        sum_q   <= sum_q + i_mem_rdata;
                    end
                end
            endcase
        end
    end

    assign o_rd_en          = (state_q == RB_REQ);
    assign o_addr           = addr_q;
    assign o_done           = done_q;
    assign o_checksum_match = match_q;

endmodule

`default_nettype wire

//--- src/mem_port_mux.sv
/*
 * memory port selector
 * phase engine or user bus onto the controller, user gating and window mask
 */
`default_nettype none

module mem_port_mux (
    input  maint_pkg::init_state_e i_state,
    input  wire                    i_zero_wr_en,
    input  maint_pkg::addr_t       i_zero_addr,
    input  wire                    i_load_wr_en,
    input  maint_pkg::addr_t       i_load_addr,
    input  maint_pkg::data_t       i_load_wdata,
    input  wire                    i_rb_rd_en,
    input  maint_pkg::addr_t       i_rb_addr,
    input  wire                    i_user_rd_en,
    input  wire                    i_user_wr_en,
    input  maint_pkg::addr_t       i_user_addr,
    input  maint_pkg::data_t       i_user_wdata,
    input  maint_pkg::ctrl_t       i_user_ctrl,
    input  wire                    i_mem_busy,
    input  maint_pkg::data_t       i_mem_rdata,
    output logic                   o_user_busy,
    output maint_pkg::data_t       o_user_rdata,
    output logic                   o_mem_rd_en,
    output logic                   o_mem_wr_en,
    output maint_pkg::addr_t       o_mem_addr,
    output maint_pkg::data_t       o_mem_wdata,
    output maint_pkg::ctrl_t       o_mem_ctrl
);
    import maint_pkg::*;

    always_comb begin
        o_mem_rd_en  = 1'b0;
        o_mem_wr_en  = 1'b0;
        o_mem_addr   = '0;
        o_mem_wdata  = '0;        // zero fill data comes from here
        o_mem_ctrl   = CTRL_FULL;
        o_user_busy  = 1'b1;      // user held off during init
        o_user_rdata = '0;
        case (i_state)
            ST_ZERO: begin
                o_mem_wr_en = i_zero_wr_en;
                o_mem_addr  = i_zero_addr;
            end
            ST_LOAD: begin
                o_mem_wr_en = i_load_wr_en;
                o_mem_addr  = i_load_addr;
                o_mem_wdata = i_load_wdata;
            end
            ST_VERIFY: begin
                o_mem_rd_en = i_rb_rd_en;
                o_mem_addr  = i_rb_addr;
            end
            ST_RUN: begin
                o_mem_rd_en  = i_user_rd_en;
                o_mem_wr_en  = i_user_wr_en;
                o_mem_addr   = i_user_addr & ADDR_WINDOW_MASK;
                o_mem_wdata  = i_user_wdata;
                o_mem_ctrl   = i_user_ctrl;
                o_user_busy  = i_mem_busy;
                o_user_rdata = i_mem_rdata;
            end
            default: ;   // calibration, port idle
        endcase
    end

    // engines and user never collide on the port
    always_comb begin
        a_rw_excl: assert #0 (!(o_mem_rd_en === 1'b1 && o_mem_wr_en === 1'b1))
            else $error("mem_port_mux: read and write enabled together");
    end

endmodule

`default_nettype wire

//--- src/maint_top.sv
/*
 * memory maintenance front end top
 * init sequencer, zero fill, image load, readback and port mux
 */
`default_nettype none

module maint_top #(
    parameter int unsigned ZERO_BYTES  = 64,
    parameter int unsigned IMAGE_BYTES = 32
) (
    input  wire                    clk,
    input  wire                    i_rst_n,
    // user bus
    input  wire                    i_rd_en,
    input  wire                    i_wr_en,
    input  maint_pkg::addr_t       i_addr,
    input  maint_pkg::data_t       i_wdata,
    input  maint_pkg::ctrl_t       i_ctrl,
    output maint_pkg::data_t       o_rdata,
    output logic                   o_busy,
    // loader stream
    input  wire                    i_ld_we,
    input  maint_pkg::data_t       i_ld_data,
    // memory controller
    output logic                   o_mem_rd_en,
    output logic                   o_mem_wr_en,
    output maint_pkg::addr_t       o_mem_addr,
    output maint_pkg::data_t       o_mem_wdata,
    output maint_pkg::ctrl_t       o_mem_ctrl,
    input  maint_pkg::data_t       i_mem_rdata,
    input  wire                    i_mem_busy,
    input  wire                    i_mem_calib_done,
    // status
    output maint_pkg::init_state_e o_init_state,
    output logic                   o_init_done,
    output logic                   o_verify_done,
    output logic                   o_checksum_match
);
    import maint_pkg::*;

    init_state_e state;
    logic        zero_active;
    logic        load_active;
    logic        verify_active;

    logic        zero_wr_en;
    addr_t       zero_addr;
    logic        zero_done;

    logic        load_wr_en;
    addr_t       load_addr;
    data_t       load_wdata;
    data_t       load_checksum;
    logic        load_done;

    logic        rb_rd_en;
    addr_t       rb_addr;
    logic        rb_done;

    init_sequencer u_seq (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_calib_done    (i_mem_calib_done),
        .i_zero_done     (zero_done),
        .i_load_done     (load_done),
        .i_verify_done   (rb_done),
        .o_zero_active   (zero_active),
        .o_load_active   (load_active),
        .o_verify_active (verify_active),
        .o_state         (state)
    );

    zero_filler #(.ZERO_BYTES(ZERO_BYTES)) u_zero (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_active   (zero_active),
        .i_mem_busy (i_mem_busy),
        .o_wr_en    (zero_wr_en),
        .o_addr     (zero_addr),
        .o_done     (zero_done)
    );

    image_loader #(.IMAGE_BYTES(IMAGE_BYTES)) u_load (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_active   (load_active),
        .i_ld_we    (i_ld_we),
        .i_ld_data  (i_ld_data),
        .i_mem_busy (i_mem_busy),
        .o_wr_en    (load_wr_en),
        .o_addr     (load_addr),
        .o_wdata    (load_wdata),
        .o_checksum (load_checksum),
        .o_done     (load_done)
    );

    readback_checker #(.IMAGE_BYTES(IMAGE_BYTES)) u_rb (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_active         (verify_active),
        .i_mem_busy       (i_mem_busy),
        .i_mem_rdata      (i_mem_rdata),
        .i_load_checksum  (load_checksum),
        .o_rd_en          (rb_rd_en),
        .o_addr           (rb_addr),
        .o_done           (rb_done),
        .o_checksum_match (o_checksum_match)
    );

    mem_port_mux u_mux (
        .i_state      (state),
        .i_zero_wr_en (zero_wr_en),
        .i_zero_addr  (zero_addr),
        .i_load_wr_en (load_wr_en),
        .i_load_addr  (load_addr),
        .i_load_wdata (load_wdata),
        .i_rb_rd_en   (rb_rd_en),
        .i_rb_addr    (rb_addr),
        .i_user_rd_en (i_rd_en),
        .i_user_wr_en (i_wr_en),
        .i_user_addr  (i_addr),
        .i_user_wdata (i_wdata),
        .i_user_ctrl  (i_ctrl),
        .i_mem_busy   (i_mem_busy),
        .i_mem_rdata  (i_mem_rdata),
        .o_user_busy  (o_busy),
        .o_user_rdata (o_rdata),
        .o_mem_rd_en  (o_mem_rd_en),
        .o_mem_wr_en  (o_mem_wr_en),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .o_mem_ctrl   (o_mem_ctrl)
    );

    assign o_init_state  = state;
    assign o_init_done   = (state == ST_RUN);
    assign o_verify_done = rb_done;

endmodule

`default_nettype wire

//--- verification/mem_model.sv
/*
 * behavioral DRAM controller for the testbench
 * calibration delay, random busy latency, byte-lane writes,
 * a write log and a word overwrite port
 */
`default_nettype none

module mem_model #(
    parameter int CALIB_CYCLES = 10,
    parameter int SEED         = 97
) (
    input  wire         clk,
    input  wire         i_rst_n,
    input  wire         i_rd_en,
    input  wire         i_wr_en,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_wdata,
    input  logic [3:0]  i_ctrl,
    output logic [31:0] o_rdata,
    output logic        o_busy,
    output logic        o_calib_done,
    input  wire         i_poke,
    input  logic [31:0] i_poke_addr,
    input  logic [31:0] i_poke_data,
    output int          o_wr_count
);
    logic [31:0] mem      [0:1023];   // 4 KiB, aliased by addr[11:2]
    logic [31:0] log_addr [0:255];
    logic [31:0] log_data [0:255];
    logic [3:0]  log_ctrl [0:255];

    integer      seed;
    int          calib_cnt;
    int          lat_cnt;
    logic        pend_wr;
    logic [31:0] pend_addr;
    logic [31:0] pend_data;
    logic [3:0]  pend_ctrl;

    initial begin
        seed = SEED;
        for (int i = 0; i < 1024; i++)
            mem[i] = 32'hc0de_0000 + i * 4;   // unwritten words show their address
    end

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy       <= 1'b0;
            o_calib_done <= 1'b0;
            o_rdata      <= '0;
            o_wr_count   <= 0;
            calib_cnt    <= 0;
            lat_cnt      <= 0;
            pend_wr      <= 1'b0;
        end else begin
            if (!o_calib_done) begin
                calib_cnt <= calib_cnt + 1;
                if (calib_cnt == CALIB_CYCLES - 1)
                    o_calib_done <= 1'b1;
            end
            if (o_busy) begin
                if (lat_cnt <= 1) begin
                    o_busy <= 1'b0;
                    // write is logged once it completes
                    if (pend_wr && o_wr_count < 256) begin
                        log_addr[o_wr_count] <= pend_addr;
                        log_data[o_wr_count] <= pend_data;
                        log_ctrl[o_wr_count] <= pend_ctrl;
                        o_wr_count           <= o_wr_count + 1;
                    end
                end else begin
                    lat_cnt <= lat_cnt - 1;
                end
            end else if (i_rd_en || i_wr_en) begin
                o_busy    <= 1'b1;
                lat_cnt   <= 1 + ($unsigned($random(seed)) % 4);  // 1 to 4 busy cycles
                pend_wr   <= i_wr_en;
                pend_addr <= i_addr;
                pend_data <= i_wdata;
                pend_ctrl <= i_ctrl;
                o_rdata   <= mem[i_addr[11:2]];
                if (i_wr_en) begin
                    for (int b = 0; b < 4; b++)
                        if (i_ctrl[b])
                            mem[i_addr[11:2]][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
            if (i_poke)
                mem[i_poke_addr[11:2]] <= i_poke_data;   // silent, not logged
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_maint.sv
/*
 * testbench for the memory maintenance front end
 * clean and corrupted boot runs, init gating, table of user bus operations
 */
`default_nettype none

module tb_maint;
    import maint_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int ZERO_BYTES   = 64;
    localparam int IMAGE_BYTES  = 32;
    localparam int ZERO_WORDS   = ZERO_BYTES / 4;
    localparam int IMAGE_WORDS  = IMAGE_BYTES / 4;
    localparam int CALIB_CYCLES = 10;
    localparam int N_OPS        = 10;
    localparam int WORD_CYCLES  = 12;   // request, accept, 4 busy, restart, slack
    localparam int WATCHDOG_TIME =
        (2 * (ZERO_WORDS + 2 * IMAGE_WORDS + CALIB_CYCLES + 8) + N_OPS)
        * WORD_CYCLES * CLK_PERIOD + 1000;
    localparam logic [31:0] WINDOW       = 32'h03ff_ffff;   // 64 MiB
    localparam logic [31:0] BLOCKED_ADDR = 32'h0000_0200;

    logic        clk;
    logic        rst_n;
    logic        rd_en;
    logic        wr_en;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  ctrl;
    logic [31:0] rdata;
    logic        busy;
    logic        ld_we;
    logic [31:0] ld_data;
    logic        mem_rd_en;
    logic        mem_wr_en;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_ctrl;
    logic [31:0] mem_rdata;
    logic        mem_busy;
    logic        mem_calib_done;
    init_state_e init_state;
    logic        init_done;
    logic        verify_done;
    logic        checksum_match;
    logic        poke;
    logic [31:0] poke_addr;
    logic [31:0] poke_data;
    int          wr_count;

    integer      seed;
    logic [31:0] image [0:IMAGE_WORDS-1];
    logic [31:0] image_sum;
    logic        op_wr   [0:N_OPS-1];
    logic [31:0] op_addr [0:N_OPS-1];
    logic [31:0] op_data [0:N_OPS-1];
    logic [3:0]  op_ctrl [0:N_OPS-1];
    logic [31:0] op_exp  [0:N_OPS-1];

    maint_top #(.ZERO_BYTES(ZERO_BYTES), .IMAGE_BYTES(IMAGE_BYTES)) i_dut (
        .clk(clk), .i_rst_n(rst_n),
        .i_rd_en(rd_en), .i_wr_en(wr_en), .i_addr(addr), .i_wdata(wdata), .i_ctrl(ctrl),
        .o_rdata(rdata), .o_busy(busy),
        .i_ld_we(ld_we), .i_ld_data(ld_data),
        .o_mem_rd_en(mem_rd_en), .o_mem_wr_en(mem_wr_en), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .o_mem_ctrl(mem_ctrl), .i_mem_rdata(mem_rdata),
        .i_mem_busy(mem_busy), .i_mem_calib_done(mem_calib_done),
        .o_init_state(init_state), .o_init_done(init_done),
        .o_verify_done(verify_done), .o_checksum_match(checksum_match)
    );

    mem_model #(.CALIB_CYCLES(CALIB_CYCLES), .SEED(97)) u_mem (
        .clk(clk), .i_rst_n(rst_n),
        .i_rd_en(mem_rd_en), .i_wr_en(mem_wr_en), .i_addr(mem_addr),
        .i_wdata(mem_wdata), .i_ctrl(mem_ctrl),
        .o_rdata(mem_rdata), .o_busy(mem_busy), .o_calib_done(mem_calib_done),
        .i_poke(poke), .i_poke_addr(poke_addr), .i_poke_data(poke_data),
        .o_wr_count(wr_count)
    );

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    // inputs change just after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // status and port levels while reset is held
    task automatic check_reset_outputs();
        check_value("o_init_state", init_state, ST_CALIB);
        check_value("o_init_done", init_done, 32'h0);
        check_value("o_verify_done", verify_done, 32'h0);
        check_value("o_checksum_match", checksum_match, 32'h0);
        check_value("o_busy", busy, 32'h1);
        check_value("o_mem_rd_en", mem_rd_en, 32'h0);
        check_value("o_mem_wr_en", mem_wr_en, 32'h0);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) tick();
        check_reset_outputs();
        rst_n = 1'b1;
    endtask

    task automatic wait_state(input init_state_e st);
        while (init_state != st)
            tick();
    endtask

    task automatic set_op(input int i, input logic is_wr, input logic [31:0] a,
                          input logic [31:0] d, input logic [3:0] c, input logic [31:0] e);
        op_wr[i]   = is_wr;
        op_addr[i] = a;
        op_data[i] = d;
        op_ctrl[i] = c;
        op_exp[i]  = e;
    endtask

    // one zero write per word from address 0, full lanes
    task automatic check_zero_fill();
        for (int i = 0; i < ZERO_WORDS; i++) begin
            check_value($sformatf("zero log addr %0d", i), u_mem.log_addr[i], i * 4);
            check_value($sformatf("zero log data %0d", i), u_mem.log_data[i], 32'h0);
            check_value($sformatf("zero log ctrl %0d", i), u_mem.log_ctrl[i], 4'hf);
        end
    endtask

    task automatic feed_image();
        int idx;
        image_sum = '0;
        for (int k = 0; k < IMAGE_WORDS; k++) begin
            image[k]  = $random(seed);
            image_sum = image_sum + image[k];
            ld_we     = 1'b1;
            ld_data   = image[k];
            tick();
            ld_we = 1'b0;
            while (wr_count < ZERO_WORDS + k + 1)
                tick();
            tick();   // loader back to idle
            idx = ZERO_WORDS + k;
            check_value($sformatf("image log addr %0d", k), u_mem.log_addr[idx], k * 4);
            check_value($sformatf("image log data %0d", k), u_mem.log_data[idx], image[k]);
        end
    endtask

    task automatic run_boot(input logic corrupt);
        apply_reset();
        wr_en = 1'b1;   // held through init, must stay off the memory port
        addr  = BLOCKED_ADDR;
        wdata = 32'hdead_beef;
        while (!mem_calib_done)
            tick();
        check_value("o_init_state", init_state, ST_CALIB);
        tick();
        check_value("o_init_state", init_state, ST_ZERO);   // one cycle after calibration
        wait_state(ST_LOAD);
        wr_en = 1'b0;
        check_value("write count after zero fill", wr_count, ZERO_WORDS);
        check_zero_fill();
        feed_image();
        check_value("load_checksum", i_dut.load_checksum, image_sum);
        if (corrupt) begin
            poke      = 1'b1;
            poke_addr = 32'h0000_0008;
            poke_data = image[2] ^ 32'h0000_0100;   // one flipped bit
            tick();
            poke = 1'b0;
        end
        while (!verify_done)
            tick();
        check_value("o_checksum_match", checksum_match, corrupt ? 32'h0 : 32'h1);
        while (!init_done)
            tick();
        check_value("write count at run", wr_count, ZERO_WORDS + IMAGE_WORDS);
    endtask

    task automatic run_user_op(input int i);
        int count_before;
        count_before = wr_count;
        while (busy)
            tick();
        rd_en = !op_wr[i];
        wr_en = op_wr[i];
        addr  = op_addr[i];
        wdata = op_data[i];
        ctrl  = op_ctrl[i];
        tick();
        while (!busy)
            tick();
        rd_en = 1'b0;
        wr_en = 1'b0;
        while (busy)
            tick();
        if (op_wr[i]) begin
            check_value("user write count", wr_count, count_before + 1);
            check_value("o_mem_addr", u_mem.log_addr[count_before], op_addr[i] & WINDOW);
            check_value("o_mem_wdata", u_mem.log_data[count_before], op_data[i]);
            check_value("o_mem_ctrl", u_mem.log_ctrl[count_before], op_ctrl[i]);
        end else begin
            check_value($sformatf("o_rdata op %0d", i), rdata, op_exp[i]);
        end
    endtask

    // user side stays busy for the whole init
    always @(negedge clk) begin
        if (!init_done)
            check_value("o_busy", busy, 32'h1);
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: boot or user sequence did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        rd_en     = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        wdata     = '0;
        ctrl      = 4'hf;
        ld_we     = 1'b0;
        ld_data   = '0;
        poke      = 1'b0;
        poke_addr = '0;
        poke_data = '0;
        seed      = 97;

        set_op(0, 1'b1, 32'h0000_0100, 32'h1234_5678, 4'hf, 32'h0);
        set_op(1, 1'b0, 32'h0000_0100, 32'h0,         4'hf, 32'h1234_5678);
        set_op(2, 1'b1, 32'hfc00_0104, 32'hcafe_f00d, 4'hf, 32'h0);   // high bits dropped
        set_op(3, 1'b0, 32'h0000_0104, 32'h0,         4'hf, 32'hcafe_f00d);
        set_op(4, 1'b1, 32'h0400_0100, 32'ha5a5_a5a5, 4'hf, 32'h0);   // aliases 0x100
        set_op(5, 1'b0, 32'h0000_0100, 32'h0,         4'hf, 32'ha5a5_a5a5);
        set_op(6, 1'b1, 32'h0000_0108, 32'h1111_1111, 4'hf, 32'h0);
        set_op(7, 1'b1, 32'h0000_0108, 32'h2222_2222, 4'h3, 32'h0);   // low half only
        set_op(8, 1'b0, 32'h0000_0108, 32'h0,         4'hf, 32'h1111_2222);
        set_op(9, 1'b0, 32'h0000_0030, 32'h0,         4'hf, 32'h0);   // zero region past image

        run_boot(1'b0);
        for (int i = 0; i < N_OPS; i++)
            run_user_op(i);
        run_boot(1'b1);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/maint_pkg.sv
src/init_sequencer.sv
src/zero_filler.sv
src/image_loader.sv
src/readback_checker.sv
src/mem_port_mux.sv
src/maint_top.sv
verification/mem_model.sv
verification/tb_maint.sv
